// File: cache_geom_pkg.sv
package cache_geom_pkg;

  // --------------------------------------------------
  // Geometry of the direct-mapped cache
  // --------------------------------------------------

  localparam int num_lines      = 8;
  localparam int words_per_line = 4;
  localparam int index_bits     = 3;
  localparam int offset_bits    = 2;
  localparam int tag_bits       = 25;

  // Byte address, seen flat or split into its fields
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [tag_bits-1:0]    tag;
      logic [index_bits-1:0]  index;
      logic [offset_bits-1:0] word;
      logic [1:0]             byte_off;
    } fld;
  } cache_addr_t;

endpackage

// File: apb_pkg.sv
package apb_pkg;

  // Bus widths for both APB ports
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // Controller sequencing
  typedef enum logic [2:0] {
    idle    = 3'd0,
    lookup  = 3'd1,
    spill   = 3'd2,
    refill  = 3'd3,
    merge   = 3'd4,
    respond = 3'd5
  } ctrl_state_t;

endpackage

// File: tag_store.sv
`timescale 1ns/10ps

module tag_store (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [cache_geom_pkg::index_bits-1:0] index,
  input  logic [cache_geom_pkg::tag_bits-1:0]   tag,
  input  logic                                fill,
  input  logic                                mark_dirty,
  output logic                                hit,
  output logic                                dirty,
  output logic [cache_geom_pkg::tag_bits-1:0]   victim_tag
);

  logic [cache_geom_pkg::tag_bits-1:0] tag_array [cache_geom_pkg::num_lines];
  logic [cache_geom_pkg::num_lines-1:0] valid_bits;
  logic [cache_geom_pkg::num_lines-1:0] dirty_bits;

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------

  assign victim_tag = tag_array[index];
  assign hit        = valid_bits[index] && (tag_array[index] == tag);
  // Dirty is only ever set on a valid line
  assign dirty      = dirty_bits[index];

  // --------------------------------------------------
  // Update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (fill) begin
        valid_bits[index] <= 1'b1;
        dirty_bits[index] <= 1'b0;
      end else if (mark_dirty) begin
        dirty_bits[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_array[index] <= tag;
    end
  end

endmodule

// File: line_store.sv
`timescale 1ns/10ps

module line_store (
  input  logic                                   clk,
  input  logic [cache_geom_pkg::index_bits-1:0]  index,
  input  logic [cache_geom_pkg::offset_bits-1:0] word,
  input  logic                                   wr_en,
  input  logic [31:0]                            wr_data,
  output logic [31:0]                            rd_word
);

  // One entry per line and word
  logic [31:0] data_array [cache_geom_pkg::num_lines][cache_geom_pkg::words_per_line];

  // --------------------------------------------------
  // Word write
  // --------------------------------------------------

  // Refill words and write hits both land here
  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_array[index][word] <= wr_data;
    end
  end

  // --------------------------------------------------
  // Word read
  // --------------------------------------------------

  assign rd_word = data_array[index][word];

endmodule

// File: cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl (
  input  logic                                   clk,
  input  logic                                   reset,

  // Processor APB
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  cache_geom_pkg::cache_addr_t            paddr,
  input  logic [apb_pkg::data_width-1:0]         pwdata,
  output logic [apb_pkg::data_width-1:0]         prdata,
  output logic                                   pready,

  // Memory APB
  output logic                                   mem_psel,
  output logic                                   mem_penable,
  output logic                                   mem_pwrite,
  output logic [apb_pkg::addr_width-1:0]         mem_paddr,
  output logic [apb_pkg::data_width-1:0]         mem_pwdata,
  input  logic [apb_pkg::data_width-1:0]         mem_prdata,
  input  logic                                   mem_pready,

  // Tag and line stores
  output logic [cache_geom_pkg::index_bits-1:0]  st_index,
  output logic [cache_geom_pkg::tag_bits-1:0]    st_tag,
  output logic [cache_geom_pkg::offset_bits-1:0] st_word,
  output logic                                   tag_fill,
  output logic                                   tag_mark_dirty,
  output logic                                   line_wr_en,
  output logic [31:0]                            line_wr_data,
  input  logic                                   hit,
  input  logic                                   dirty,
  input  logic [cache_geom_pkg::tag_bits-1:0]    victim_tag,
  input  logic [31:0]                            rd_word
);

  apb_pkg::ctrl_state_t state;
  apb_pkg::ctrl_state_t next_state;

  cache_geom_pkg::cache_addr_t req_addr;
  cache_geom_pkg::cache_addr_t spill_addr;
  cache_geom_pkg::cache_addr_t refill_addr;
  logic                            req_write;
  logic [apb_pkg::data_width-1:0]  req_wdata;

  logic [cache_geom_pkg::offset_bits-1:0] word_cnt;
  logic mem_access;
  logic mem_busy;
  logic word_done;
  logic last_word;

  // --------------------------------------------------
  // Request capture and sequencing
  // --------------------------------------------------

  // Taken in the access phase, held until respond
  always_ff @(posedge clk) begin
    if (state == apb_pkg::idle && psel && penable) begin
      req_addr  <= paddr;
      req_write <= pwrite;
      req_wdata <= pwdata;
    end
  end

  assign mem_busy  = (state == apb_pkg::spill) || (state == apb_pkg::refill);
  assign word_done = mem_busy && mem_access && mem_pready;
  assign last_word = (word_cnt == cache_geom_pkg::offset_bits'(cache_geom_pkg::words_per_line - 1));

  always_comb begin
    next_state = state;
    case (state)
      apb_pkg::idle: begin
        if (psel && penable) next_state = apb_pkg::lookup;
      end
      apb_pkg::lookup: begin
        if (hit) next_state = apb_pkg::respond;
        else if (dirty) next_state = apb_pkg::spill;
        else next_state = apb_pkg::refill;
      end
      apb_pkg::spill: begin
        if (word_done && last_word) next_state = apb_pkg::refill;
      end
      apb_pkg::refill: begin
        if (word_done && last_word) begin
          next_state = req_write ? apb_pkg::merge : apb_pkg::respond;
        end
      end
      apb_pkg::merge:   next_state = apb_pkg::respond;
      apb_pkg::respond: next_state = apb_pkg::idle;
      default:          next_state = apb_pkg::idle;
    endcase
  end

  // Word counter wraps back to 0 after the last word
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= apb_pkg::idle;
      word_cnt   <= '0;
      mem_access <= 1'b0;
    end else begin
      state <= next_state;
      if (state == apb_pkg::lookup) begin
        word_cnt <= '0;
      end
      if (mem_busy) begin
        if (!mem_access) begin
          mem_access <= 1'b1;
        end else if (mem_pready) begin
          mem_access <= 1'b0;
          word_cnt   <= word_cnt + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Memory port
  // --------------------------------------------------

  always_comb begin
    spill_addr              = req_addr;
    spill_addr.fld.tag      = victim_tag;
    spill_addr.fld.word     = word_cnt;
    spill_addr.fld.byte_off = 2'b00;
    refill_addr              = req_addr;
    refill_addr.fld.word     = word_cnt;
    refill_addr.fld.byte_off = 2'b00;
  end

  assign mem_psel    = mem_busy;
  assign mem_penable = mem_access;
  assign mem_pwrite  = (state == apb_pkg::spill);
  assign mem_paddr   = (state == apb_pkg::spill) ? spill_addr.flat : refill_addr.flat;
  assign mem_pwdata  = rd_word;

  // --------------------------------------------------
  // Store control and processor response
  // --------------------------------------------------

  assign st_index = req_addr.fld.index;
  assign st_tag   = req_addr.fld.tag;
  assign st_word  = mem_busy ? word_cnt : req_addr.fld.word;

  // Tag goes in with the last refill word
  assign tag_fill       = (state == apb_pkg::refill) && word_done && last_word;
  assign tag_mark_dirty = ((state == apb_pkg::lookup) && hit && req_write) ||
                          (state == apb_pkg::merge);
  assign line_wr_en     = ((state == apb_pkg::refill) && word_done) || tag_mark_dirty;
  assign line_wr_data   = (state == apb_pkg::refill) ? mem_prdata : req_wdata;

  assign prdata = rd_word;
  assign pready = (state == apb_pkg::respond);

endmodule

// File: cache_top.sv
`timescale 1ns/10ps

module cache_top (
  input  logic                           clk,
  input  logic                           reset,

  // Processor APB
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [apb_pkg::addr_width-1:0] paddr,
  input  logic [apb_pkg::data_width-1:0] pwdata,
  output logic [apb_pkg::data_width-1:0] prdata,
  output logic                           pready,

  // Memory APB
  output logic                           mem_psel,
  output logic                           mem_penable,
  output logic                           mem_pwrite,
  output logic [apb_pkg::addr_width-1:0] mem_paddr,
  output logic [apb_pkg::data_width-1:0] mem_pwdata,
  input  logic [apb_pkg::data_width-1:0] mem_prdata,
  input  logic                           mem_pready
);

  logic [cache_geom_pkg::index_bits-1:0]  st_index;
  logic [cache_geom_pkg::tag_bits-1:0]    st_tag;
  logic [cache_geom_pkg::offset_bits-1:0] st_word;
  logic                                   tag_fill;
  logic                                   tag_mark_dirty;
  logic                                   line_wr_en;
  logic [31:0]                            line_wr_data;
  logic                                   hit;
  logic                                   dirty;
  logic [cache_geom_pkg::tag_bits-1:0]    victim_tag;
  logic [31:0]                            rd_word;

  // --------------------------------------------------
  // Tag and data stores
  // --------------------------------------------------

  tag_store u_tags (
    .clk        (clk),
    .reset      (reset),
    .index      (st_index),
    .tag        (st_tag),
    .fill       (tag_fill),
    .mark_dirty (tag_mark_dirty),
    .hit        (hit),
    .dirty      (dirty),
    .victim_tag (victim_tag)
  );

  line_store u_lines (
    .clk     (clk),
    .index   (st_index),
    .word    (st_word),
    .wr_en   (line_wr_en),
    .wr_data (line_wr_data),
    .rd_word (rd_word)
  );

  // --------------------------------------------------
  // Controller
  // --------------------------------------------------

  cache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .mem_psel       (mem_psel),
    .mem_penable    (mem_penable),
    .mem_pwrite     (mem_pwrite),
    .mem_paddr      (mem_paddr),
    .mem_pwdata     (mem_pwdata),
    .mem_prdata     (mem_prdata),
    .mem_pready     (mem_pready),
    .st_index       (st_index),
    .st_tag         (st_tag),
    .st_word        (st_word),
    .tag_fill       (tag_fill),
    .tag_mark_dirty (tag_mark_dirty),
    .line_wr_en     (line_wr_en),
    .line_wr_data   (line_wr_data),
    .hit            (hit),
    .dirty          (dirty),
    .victim_tag     (victim_tag),
    .rd_word        (rd_word)
  );

endmodule

// File: cache_checker.sv
`timescale 1ns/10ps

module cache_checker (
  input  logic            clk,
  input  logic            reset,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [31:0]     paddr,
  input  logic [31:0]     pwdata,
  input  logic [31:0]     prdata,
  input  logic            pready,
  input  logic            mem_psel,
  input  logic            mem_penable,
  input  logic            mem_pwrite,
  input  logic [31:0]     mem_paddr,
  input  logic [31:0]     mem_pwdata,
  input  logic            mem_pready,
  input  logic [8*20-1:0] test_name,
  input  logic [31:0]     exp_rdata,
  input  int              exp_mem_wr,
  input  int              exp_mem_rd,
  output int              error_count,
  output int              check_count
);

  // Access-phase cycles with pready low on a hit
  localparam int hit_latency = 2;

  // Memory as the processor has written it
  logic [31:0] shadow [logic [29:0]];
  // Tag of the line each index was last refilled from
  logic [24:0] line_tag [8];
  logic [31:0] exp_addr;
  int          wr_seen;
  int          rd_seen;
  int          access_wait;
  logic        after_reset;

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (shadow.exists(addr[31:2])) begin
      return shadow[addr[31:2]];
    end
    return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      wr_seen     = 0;
      rd_seen     = 0;
      access_wait = 0;
      error_count = 0;
      check_count = 0;
      after_reset = 1'b1;
    end else begin
      if (after_reset) begin
        after_reset = 1'b0;
        check_count = check_count + 1;
        if (pready !== 1'b0 || mem_psel !== 1'b0 || mem_penable !== 1'b0) begin
          $display("Bus not idle after reset: pready %b, mem_psel %b, mem_penable %b",
                   pready, mem_psel, mem_penable);
          error_count = error_count + 1;
        end
      end

      // --------------------------------------------------
      // Memory side, spill writes then refill reads
      // --------------------------------------------------

      if (mem_psel && mem_penable && mem_pready) begin
        check_count = check_count + 1;
        if (mem_pwrite) begin
          exp_addr = {line_tag[paddr[6:4]], paddr[6:4], wr_seen[1:0], 2'b00};
          if (rd_seen != 0) begin
            $display("Spill write %0d of %0s came after a refill read", wr_seen, test_name);
            error_count = error_count + 1;
          end
          if (mem_paddr !== exp_addr) begin
            $display("Mismatch %0s spill address: expected %h, actual %h",
                     test_name, exp_addr, mem_paddr);
            error_count = error_count + 1;
          end
          if (mem_pwdata !== expected_word(mem_paddr)) begin
            $display("Mismatch %0s spill data at %h: expected %h, actual %h",
                     test_name, mem_paddr, expected_word(mem_paddr), mem_pwdata);
            error_count = error_count + 1;
          end
          wr_seen = wr_seen + 1;
        end else begin
          exp_addr = {paddr[31:4], rd_seen[1:0], 2'b00};
          if (mem_paddr !== exp_addr) begin
            $display("Mismatch %0s refill address: expected %h, actual %h",
                     test_name, exp_addr, mem_paddr);
            error_count = error_count + 1;
          end
          line_tag[paddr[6:4]] = paddr[31:7];
          rd_seen = rd_seen + 1;
        end
      end

      // --------------------------------------------------
      // Processor side
      // --------------------------------------------------

      if (psel && penable && !pready) begin
        access_wait = access_wait + 1;
      end

      if (psel && penable && pready) begin
        check_count = check_count + 1;
        if (pwrite) begin
          shadow[paddr[31:2]] = pwdata;
        end else if (prdata !== exp_rdata) begin
          $display("Mismatch %0s read data: expected %h, actual %h",
                   test_name, exp_rdata, prdata);
          error_count = error_count + 1;
        end
        if (wr_seen != exp_mem_wr) begin
          $display("Mismatch %0s memory writes: expected %0d, actual %0d",
                   test_name, exp_mem_wr, wr_seen);
          error_count = error_count + 1;
        end
        if (rd_seen != exp_mem_rd) begin
          $display("Mismatch %0s memory reads: expected %0d, actual %0d",
                   test_name, exp_mem_rd, rd_seen);
          error_count = error_count + 1;
        end
        if (exp_mem_wr == 0 && exp_mem_rd == 0 && access_wait != hit_latency) begin
          $display("Mismatch %0s hit latency: expected %0d, actual %0d",
                   test_name, hit_latency, access_wait);
          error_count = error_count + 1;
        end
        wr_seen     = 0;
        rd_seen     = 0;
        access_wait = 0;
      end
    end
  end

endmodule

// File: tb_cache.sv
`timescale 1ns/10ps

module tb_cache;

  localparam int ready_timeout = 200;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        mem_psel;
  logic        mem_penable;
  logic        mem_pwrite;
  logic [31:0] mem_paddr;
  logic [31:0] mem_pwdata;
  logic [31:0] mem_prdata;
  logic        mem_pready;

  // Expected results handed to the checker with each request
  logic [8*20-1:0] test_name;
  logic [31:0]     exp_rdata;
  int              exp_mem_wr;
  int              exp_mem_rd;
  int              error_count;
  int              check_count;
  int              timeout_count;

  // Memory model state
  integer      seed;
  logic [31:0] mem [logic [29:0]];
  logic [31:0] read_word;
  int          wait_left;

  cache_top UUT (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .mem_psel    (mem_psel),
    .mem_penable (mem_penable),
    .mem_pwrite  (mem_pwrite),
    .mem_paddr   (mem_paddr),
    .mem_pwdata  (mem_pwdata),
    .mem_prdata  (mem_prdata),
    .mem_pready  (mem_pready)
  );

  cache_checker u_check (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .mem_psel    (mem_psel),
    .mem_penable (mem_penable),
    .mem_pwrite  (mem_pwrite),
    .mem_paddr   (mem_paddr),
    .mem_pwdata  (mem_pwdata),
    .mem_pready  (mem_pready),
    .test_name   (test_name),
    .exp_rdata   (exp_rdata),
    .exp_mem_wr  (exp_mem_wr),
    .exp_mem_rd  (exp_mem_rd),
    .error_count (error_count),
    .check_count (check_count)
  );

  always #20 clk = ~clk;

  // Untouched memory holds its word address XOR a fixed pattern
  function automatic logic [31:0] boot_value(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
  endfunction

  // --------------------------------------------------
  // Memory model, 0 to 3 wait states per word
  // --------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (mem_psel && mem_penable && mem_pready) begin
        if (mem_pwrite) begin
          mem[mem_paddr[31:2]] = mem_pwdata;
        end
        #1;
        mem_pready = 1'b0;
      end else if (mem_psel && !mem_penable) begin
        wait_left = $unsigned($random(seed)) % 4;
        if (mem.exists(mem_paddr[31:2])) begin
          read_word = mem[mem_paddr[31:2]];
        end else begin
          read_word = boot_value(mem_paddr);
        end
        #1;
        mem_prdata = read_word;
        mem_pready = (wait_left == 0);
      end else if (mem_psel && mem_penable) begin
        wait_left = wait_left - 1;
        #1;
        mem_pready = (wait_left == 0);
      end
    end
  end

  // --------------------------------------------------
  // Processor APB transfer
  // --------------------------------------------------

  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(posedge clk);
    while (!pready && cycles < ready_timeout) begin
      cycles = cycles + 1;
      @(posedge clk);
    end
    if (!pready) begin
      $display("Timeout: no pready for %0s after %0d cycles", test_name, cycles);
      timed_out = 1'b1;
    end
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  initial begin
    int              fd;
    int              n;
    logic [8*128-1:0] line_buf;
    logic [8*20-1:0] name;
    logic [15:0]     op;
    logic [31:0]     addr;
    logic [31:0]     wdata;
    logic [31:0]     rdata;
    int              nwr;
    int              nrd;
    logic            timed_out;
    logic            open_failed;

    clk           = 1'b0;
    reset         = 1'b1;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    mem_prdata    = '0;
    mem_pready    = 1'b0;
    seed          = 32'hb82c4315;
    test_name     = "reset";
    exp_rdata     = '0;
    exp_mem_wr    = 0;
    exp_mem_rd    = 0;
    timeout_count = 0;
    timed_out     = 1'b0;
    open_failed   = 1'b0;

    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    fd = $fopen("cache_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open cache_testdata.txt");
      open_failed = 1'b1;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        if (n > 0) begin
          n = $sscanf(line_buf, "%s %s %h %h %h %d %d",
                      name, op, addr, wdata, rdata, nwr, nrd);
          // Comment and blank lines fall through here
          if (n == 7 && (op == "rd" || op == "wr")) begin
            test_name  = name;
            exp_rdata  = rdata;
            exp_mem_wr = nwr;
            exp_mem_rd = nrd;
            apb_transfer(op == "wr", addr, wdata, timed_out);
            if (timed_out) begin
              timeout_count = timeout_count + 1;
            end
          end
        end
      end
      $fclose(fd);
    end

    repeat (2) @(posedge clk);
    $display("Checks %0d, mismatches %0d, timeouts %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0 && check_count > 0 && !open_failed) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: cache_testdata.txt
# name op(rd/wr) addr wdata exp_rdata mem_writes mem_reads
# hex for addr and data, exp_rdata unused on wr, counts are memory words per request
cold_miss     rd 00001000 00000000 5a5a0400 0 4
hit_word1     rd 00001004 00000000 5a5a0401 0 0
hit_word3     rd 0000100c 00000000 5a5a0403 0 0
write_hit     wr 00001008 deadbeef 00000000 0 0
read_back     rd 00001008 00000000 deadbeef 0 0
neighbor      rd 00001004 00000000 5a5a0401 0 0
byte_offset   rd 0000100e 00000000 5a5a0403 0 0
spill_miss    rd 00002004 00000000 5a5a0801 4 4
spill_other   rd 00002000 00000000 5a5a0800 0 0
reload        rd 00001008 00000000 deadbeef 0 4
reload_w0     rd 00001000 00000000 5a5a0400 0 0
wmiss_clean   wr 00003054 12345678 00000000 0 4
wmiss_read    rd 00003054 00000000 12345678 0 0
wmiss_w0      rd 00003050 00000000 5a5a0c14 0 0
wmiss_w3      rd 0000305c 00000000 5a5a0c17 0 0
evict_merged  rd 00004050 00000000 5a5a1014 4 4
merged_back   rd 00003054 00000000 12345678 0 4
wr_line2      wr 00000020 a5a5a5a5 00000000 0 4
wr_line2_w3   wr 0000002c 0badf00d 00000000 0 0
wmiss_dirty   wr 000010a0 11112222 00000000 4 4
spill_merged  rd 00000020 00000000 a5a5a5a5 4 4
line2_w3      rd 0000002c 00000000 0badf00d 0 0
line2_w1      rd 00000024 00000000 5a5a0009 0 0
merged_reload rd 000010a0 00000000 11112222 0 4
merged_w1     rd 000010a4 00000000 5a5a0429 0 0
top_line      rd fffffff0 00000000 65a5fffc 0 4
top_line_w3   rd fffffffc 00000000 65a5ffff 0 0

// File: sources.f
cache_geom_pkg.sv
apb_pkg.sv
tag_store.sv
line_store.sv
cache_ctrl.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f sources.f --top-module tb_cache -o tb_cache_sim
output="$(./obj_dir/tb_cache_sim)"
echo "$output"

if echo "$output" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi
exit 1
